// File: Makefile
VERILATOR ?= verilator
TOP       ?= cfg_serial_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
rtl/vic_cfg_pkg.sv
rtl/serial_link_pkg.sv
rtl/config_reporter.sv
rtl/config_fifo.sv
rtl/serial_tx.sv
rtl/cfg_serial_top.sv
test/cfg_serial_props.sv
test/cfg_serial_tb.sv

// File: rtl/cfg_serial_top.sv
`timescale 1ns/1ps

module cfg_serial_top
    import serial_link_pkg::*;
#(
    parameter int DEPTH        = 4, // buffer slots and starting credits
    parameter int CLKS_PER_BIT = 8  // clk_serial cycles per uart bit
) (
    input  logic       clk_serial,
    input  logic       reset,
    input  logic [1:0] chip,                 // chip model pins
    input  logic       is_15khz,             // frequency option pin
    input  logic       is_hide_raster_lines, // raster line option pin
    input  logic       cclk,                 // microcontroller ready
    output logic       tx                    // uart line to the microcontroller
);

    link_entry_t push;          // reporter to buffer
    link_entry_t head;          // buffer head seen by the transmitter
    logic        credit_return; // buffer back to reporter
    logic        take;          // transmitter pops head

    config_reporter #(.DEPTH(DEPTH)) u_reporter (
        .clk_serial           (clk_serial),
        .reset                (reset),
        .chip                 (chip),
        .is_15khz             (is_15khz),
        .is_hide_raster_lines (is_hide_raster_lines),
        .credit_return        (credit_return),
        .push                 (push)
    );

    config_fifo #(.DEPTH(DEPTH)) u_fifo (
        .clk_serial    (clk_serial),
        .reset         (reset),
        .push          (push),
        .take          (take),
        .head          (head),
        .credit_return (credit_return)
    );

    serial_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk_serial (clk_serial),
        .reset      (reset),
        .cclk       (cclk),
        .head       (head),
        .take       (take),
        .tx         (tx)
    );

endmodule

// File: rtl/config_fifo.sv
`timescale 1ns/1ps

module config_fifo
    import vic_cfg_pkg::*;
    import serial_link_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic        clk_serial,
    input  logic        reset,
    input  link_entry_t push,
    input  logic        take,
    output link_entry_t head,
    output logic        credit_return
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cfg_report_t      mem [DEPTH]; // report slots
    logic [PTR_W-1:0] wr_ptr;      // next slot to fill
    logic [PTR_W-1:0] rd_ptr;      // slot shown on head
    logic [CNT_W-1:0] count;       // occupied slots
    logic             pop;

    // wrap at DEPTH so any depth works, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop           = take && head.valid; // take on empty is ignored
    assign credit_return = pop;                // one credit back per entry taken

    always_comb begin
        head.valid  = (count != '0);
        head.report = mem[rd_ptr];
    end

    always_ff @(posedge clk_serial) begin
        if (push.valid) begin
            mem[wr_ptr] <= push.report;
        end
    end

    // no full check, the reporter never pushes without a credit
    always_ff @(posedge clk_serial) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push.valid) wr_ptr <= ptr_next(wr_ptr);
            if (pop)        rd_ptr <= ptr_next(rd_ptr);
            count <= count + CNT_W'(push.valid) - CNT_W'(pop);
        end
    end

endmodule

// File: rtl/config_reporter.sv
`timescale 1ns/1ps

module config_reporter
    import vic_cfg_pkg::*;
    import serial_link_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic        clk_serial,
    input  logic        reset,
    input  logic [1:0]  chip,
    input  logic        is_15khz,
    input  logic        is_hide_raster_lines,
    input  logic        credit_return,
    output link_entry_t push
);

    localparam int CRED_W = $clog2(DEPTH + 1); // holds 0..DEPTH

    vic_cfg_t          pins_raw;    // async pins in report layout
    vic_cfg_t          sync_1;      // first synchronizer stage
    vic_cfg_t          sync_2;      // second stage, safe to use
    vic_cfg_t          last_cfg;    // config of the last captured report
    logic              booted;      // boot report already captured
    logic              capture;     // new report goes into pending
    logic              pend_valid;  // pending report waits for a credit
    cfg_report_t       pend_report;
    logic [CRED_W-1:0] credits;     // free slots in the buffer
    logic              fire;        // pending goes out this cycle

    always_comb begin
        pins_raw.hide_raster = is_hide_raster_lines;
        pins_raw.is_15khz    = is_15khz;
        pins_raw.chip        = chip_e'(chip);
    end

    // 2-flop synchronizer, keeps tracking the pins during reset
    always_ff @(posedge clk_serial) begin
        sync_1 <= pins_raw;
        sync_2 <= sync_1;
    end

    // boot report on the first cycle out of reset, later only on a real change
    assign capture = !booted || (sync_2 != last_cfg);
    assign fire    = pend_valid && (credits != '0);

    always_comb begin
        push.valid  = fire;
        push.report = pend_report;
    end

    // a newer capture simply overwrites an unsent pending report
    always_ff @(posedge clk_serial) begin
        if (capture) begin
            last_cfg        <= sync_2;
            pend_report.op  <= booted ? OP_CHANGE : OP_BOOT;
            pend_report.cfg <= sync_2;
        end
    end

    always_ff @(posedge clk_serial) begin
        if (reset) begin
            booted     <= 1'b0;
            pend_valid <= 1'b0;
            credits    <= CRED_W'(DEPTH); // buffer starts empty
        end else begin
            if (capture) begin
                booted     <= 1'b1;
                pend_valid <= 1'b1; // stays set if a push leaves at the same edge
            end else if (fire) begin
                pend_valid <= 1'b0;
            end
            // a spend and a return in one cycle cancel out
            credits <= credits + CRED_W'(credit_return) - CRED_W'(fire);
        end
    end

endmodule

// File: rtl/serial_link_pkg.sv
package serial_link_pkg;

    import vic_cfg_pkg::*;

    // one queue slot, used on push and on head
    typedef struct packed {
        logic        valid;  // slot holds a report
        cfg_report_t report; // byte to send
    } link_entry_t;

    // uart 8n1 transmitter states
    typedef enum logic [1:0] {
        TX_IDLE,  // line high, waiting for cclk and data
        TX_START, // start bit, line low
        TX_DATA,  // eight data bits, lsb first
        TX_STOP   // stop bit, line high
    } tx_state_e;

endpackage

// File: rtl/serial_tx.sv
`timescale 1ns/1ps

module serial_tx
    import serial_link_pkg::*;
#(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic        clk_serial,
    input  logic        reset,
    input  logic        cclk,
    input  link_entry_t head,
    output logic        take,
    output logic        tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    tx_state_e        state;
    logic [CNT_W-1:0] bit_cnt;   // cycles spent in the current bit
    logic [2:0]       bit_idx;   // data bit being sent
    logic [7:0]       shreg;     // remaining data bits, next one in bit 0
    logic             bit_end;   // last cycle of a bit time
    logic             shift_now; // next data bit moves onto the line

    // only start a frame while the microcontroller is ready
    assign take      = (state == TX_IDLE) && cclk && head.valid;
    assign bit_end   = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign shift_now = bit_end && ((state == TX_START) || (state == TX_DATA));

    always_ff @(posedge clk_serial) begin
        if (take) begin
            shreg <= head.report; // latch head in the take cycle
        end else if (shift_now) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge clk_serial) begin
        if (reset) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1; // line idles high
        end else begin
            bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (take) begin
                        state <= TX_START;
                        tx    <= 1'b0; // start bit from the next cycle on
                    end else begin
                        tx <= 1'b1;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state <= TX_DATA;
                        tx    <= shreg[0]; // bit 0 first
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shreg[0];
                        end
                    end
                end
                TX_STOP: begin
                    // cclk is not looked at here, a started frame always ends
                    if (bit_end) state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/vic_cfg_pkg.sv
package vic_cfg_pkg;

    // chip model strapped by the microcontroller, 2 config pins
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0, // ntsc, 65 cycles per line
        CHIP_6569R3   = 2'd1, // pal, 63 cycles per line
        CHIP_6567R56A = 2'd2, // early ntsc, 64 cycles per line
        CHIP_6569R1   = 2'd3  // early pal
    } chip_e;

    // upper nibble of every report byte
    typedef enum logic [3:0] {
        OP_BOOT   = 4'hA, // first report after reset
        OP_CHANGE = 4'hC  // any later report
    } report_op_e;

    // configuration as seen on the pins, chip in the low bits
    typedef struct packed {
        logic  hide_raster; // bit 3
        logic  is_15khz;    // bit 2
        chip_e chip;        // bits 1:0
    } vic_cfg_t;

    // one byte on the serial line
    typedef struct packed {
        report_op_e op;  // bits 7:4
        vic_cfg_t   cfg; // bits 3:0
    } cfg_report_t;

endpackage

// File: test/cfg_serial_props.sv
`timescale 1ns/1ps

module cfg_serial_props #(
    parameter int DEPTH = 4
) (
    input logic                       clk_serial,
    input logic                       reset,
    input logic [$clog2(DEPTH+1)-1:0] credits,    // reporter credit count
    input logic                       push_valid, // reporter pushes an entry
    input logic [$clog2(DEPTH+1)-1:0] count,      // buffer occupancy
    input logic                       tx
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic reset_seen = 1'b0; // high once a reset edge has set tx

    always @(posedge clk_serial) begin
        if (reset) reset_seen <= 1'b1;
    end

    credits_bounded: assert property (@(posedge clk_serial) disable iff (reset)
        credits <= CNT_W'(DEPTH))
        else $error("reporter holds more credits than buffer slots");

    // every push must be covered by a free slot
    push_has_credit: assert property (@(posedge clk_serial) disable iff (reset)
        push_valid |-> (count != CNT_W'(DEPTH)))
        else $error("push issued into a full buffer");

    occupancy_bounded: assert property (@(posedge clk_serial) disable iff (reset)
        count <= CNT_W'(DEPTH))
        else $error("buffer occupancy above depth");

    tx_idle_in_reset: assert property (@(posedge clk_serial)
        (reset && reset_seen) |-> tx)
        else $error("tx not high while in reset");

endmodule

bind cfg_serial_top cfg_serial_props #(.DEPTH(DEPTH)) i_props (
    .clk_serial (clk_serial),
    .reset      (reset),
    .credits    (u_reporter.credits),
    .push_valid (push.valid),
    .count      (u_fifo.count),
    .tx         (tx)
);

// File: test/cfg_serial_tb.sv
`timescale 1ns/1ps

module cfg_serial_tb
    import vic_cfg_pkg::*;
();

    localparam int DEPTH          = 4;
    localparam int CLKS_PER_BIT   = 8;
    localparam int FRAME_CYCLES   = 10 * CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = 50 * FRAME_CYCLES; // ~20 frames, 500 gated cycles, quiet rounds

    logic       clk_serial;
    logic       reset;
    logic [1:0] chip;
    logic       is_15khz;
    logic       is_hide_raster_lines;
    logic       cclk;
    logic       tx;

    vic_cfg_t cur_cfg;         // config now driven on the pins
    integer   seed;
    int       cycle_count = 0;

    cfg_serial_top #(.DEPTH(DEPTH), .CLKS_PER_BIT(CLKS_PER_BIT)) i_dut (
        .clk_serial           (clk_serial),
        .reset                (reset),
        .chip                 (chip),
        .is_15khz             (is_15khz),
        .is_hide_raster_lines (is_hide_raster_lines),
        .cclk                 (cclk),
        .tx                   (tx)
    );

    initial begin
        clk_serial = 1'b0;
        forever #4 clk_serial = ~clk_serial; // 8 ns period
    end

    always @(posedge clk_serial) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    function automatic vic_cfg_t make_cfg(input chip_e c, input logic khz, input logic hide);
        vic_cfg_t cfg;
        cfg.chip        = c;
        cfg.is_15khz    = khz;
        cfg.hide_raster = hide;
        return cfg;
    endfunction

    // byte layout: opcode high nibble, config low nibble
    function automatic cfg_report_t report_of(input report_op_e op, input vic_cfg_t cfg);
        cfg_report_t r;
        r.op  = op;
        r.cfg = cfg;
        return r;
    endfunction

    task automatic apply_config(input vic_cfg_t cfg);
        @(negedge clk_serial);
        chip                 = cfg.chip;
        is_15khz             = cfg.is_15khz;
        is_hide_raster_lines = cfg.hide_raster;
        cur_cfg              = cfg;
    endtask

    // uart 8n1 decoder, samples near the middle of each bit
    task automatic receive_byte(output logic [7:0] data);
        @(negedge tx);
        repeat (CLKS_PER_BIT / 2) @(negedge clk_serial);
        if (tx !== 1'b0) begin
            $display("start bit on tx did not stay low for half a bit time");
            fail_run();
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk_serial);
            data[i] = tx; // lsb first
        end
        repeat (CLKS_PER_BIT) @(negedge clk_serial);
        if (tx !== 1'b1) begin
            $display("stop bit on tx was low, frame is broken");
            fail_run();
        end
    endtask

    task automatic expect_frame(input cfg_report_t exp);
        logic [7:0]  raw;
        cfg_report_t got;
        receive_byte(raw);
        got = raw;
        check_value("report.op", 8'(got.op), 8'(exp.op));
        check_value("report.cfg.hide_raster", 8'(got.cfg.hide_raster), 8'(exp.cfg.hide_raster));
        check_value("report.cfg.is_15khz", 8'(got.cfg.is_15khz), 8'(exp.cfg.is_15khz));
        check_value("report.cfg.chip", 8'(got.cfg.chip), 8'(exp.cfg.chip));
    endtask

    task automatic expect_line_idle(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk_serial);
            if (tx !== 1'b1) begin
                $display("unexpected frame start on tx while %s", what);
                fail_run();
            end
        end
    endtask

    task automatic boot_report_test();
        check_value("tx", 8'(tx), 8'h01); // idle high right after reset
        expect_frame(report_of(OP_BOOT, cur_cfg));
    endtask

    // one field at a time, chip first
    task automatic field_change_test();
        vic_cfg_t nxt_cfg;
        nxt_cfg      = cur_cfg;
        nxt_cfg.chip = CHIP_6567R56A;
        apply_config(nxt_cfg);
        expect_frame(report_of(OP_CHANGE, cur_cfg));
        nxt_cfg.is_15khz = ~nxt_cfg.is_15khz;
        apply_config(nxt_cfg);
        expect_frame(report_of(OP_CHANGE, cur_cfg));
        nxt_cfg.hide_raster = ~nxt_cfg.hide_raster;
        apply_config(nxt_cfg);
        expect_frame(report_of(OP_CHANGE, cur_cfg));
    endtask

    task automatic cclk_gating_test();
        @(negedge clk_serial);
        cclk = 1'b0;
        apply_config(make_cfg(CHIP_6569R1, 1'b1, 1'b1));
        expect_line_idle(500, "cclk is low");
        @(negedge clk_serial);
        cclk = 1'b1; // releases the queued report
        expect_frame(report_of(OP_CHANGE, cur_cfg));
    endtask

    // 4 reports fill the buffer, 5th and 6th coalesce in pending
    task automatic back_pressure_test();
        vic_cfg_t    steps [6];
        cfg_report_t exp_q [$];
        steps[0] = make_cfg(CHIP_6567R8, 1'b0, 1'b0);
        steps[1] = make_cfg(CHIP_6569R3, 1'b0, 1'b0);
        steps[2] = make_cfg(CHIP_6567R56A, 1'b1, 1'b0);
        steps[3] = make_cfg(CHIP_6569R1, 1'b0, 1'b1);
        steps[4] = make_cfg(CHIP_6567R8, 1'b1, 1'b1);
        steps[5] = make_cfg(CHIP_6567R56A, 1'b0, 1'b1);
        @(negedge clk_serial);
        cclk = 1'b0;
        for (int i = 0; i < 6; i++) begin
            apply_config(steps[i]);
            repeat (10) @(negedge clk_serial); // hold each config
            if (i < DEPTH) exp_q.push_back(report_of(OP_CHANGE, steps[i]));
        end
        exp_q.push_back(report_of(OP_CHANGE, steps[5])); // only the latest survives
        @(negedge clk_serial);
        cclk = 1'b1;
        while (exp_q.size() > 0) expect_frame(exp_q.pop_front());
        expect_line_idle(2 * FRAME_CYCLES, "the queue should be drained");
    endtask

    task automatic random_config_test();
        logic [31:0] r;
        vic_cfg_t    nxt_cfg;
        for (int round = 0; round < 10; round++) begin
            r       = $random(seed);
            nxt_cfg = r[3:0]; // hide, khz, chip from msb down
            if (nxt_cfg == cur_cfg) begin
                apply_config(nxt_cfg);
                expect_line_idle(200, "a repeated config is on the pins");
            end else begin
                apply_config(nxt_cfg);
                expect_frame(report_of(OP_CHANGE, cur_cfg));
            end
        end
    endtask

    initial begin
        reset                = 1'b1;
        cclk                 = 1'b1;
        seed                 = 32'h18f75cdf;
        cur_cfg              = make_cfg(CHIP_6569R3, 1'b0, 1'b0);
        chip                 = cur_cfg.chip;
        is_15khz             = cur_cfg.is_15khz;
        is_hide_raster_lines = cur_cfg.hide_raster;
        repeat (10) @(negedge clk_serial);
        reset = 1'b0;
        boot_report_test();
        field_change_test();
        cclk_gating_test();
        back_pressure_test();
        random_config_test();
        $display("NO ERRORS");
        $finish;
    end

endmodule
